/* audio_bus_master.sv */
`timescale 1ns/1ps
`include "drum_cfg.svh"

module audio_bus_master (
	input logic CLOCK_50,
	input logic reset,
	input drum_pkg::node_t sample,
	input logic sample_ready,
	input logic bus_ack,
	input logic [31:0] bus_read_data,
	output logic [31:0] bus_addr,
	output logic [3:0] bus_byte_enable,
	output logic bus_read,
	output logic bus_write,
	output logic [31:0] bus_write_data,
	output logic [7:0] fifo_space,
	output logic step_go
);

	drum_pkg::audio_state_t state;
	logic [31:0] sample_word;

	// Full word transfers only
	assign bus_byte_enable = 4'b1111;

	// Sign extend the node height, then scale into the audio range
	assign sample_word = {{(32 - `NODE_W){sample[`NODE_W-1]}}, sample} << `SAMPLE_SHIFT;

	////////////////////////////////////////
	// Bus master FSM
	////////////////////////////////////////
	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			state <= drum_pkg::fifo_req;
			bus_read <= 1'b0;
			bus_write <= 1'b0;
			step_go <= 1'b0;
			fifo_space <= '0;
		end else begin
			step_go <= 1'b0;
			case (state)
				drum_pkg::fifo_req: begin
					bus_addr <= `AUDIO_FIFO_ADDR;
					bus_read <= 1'b1;
					state <= drum_pkg::fifo_wait;
				end
				drum_pkg::fifo_wait: begin
					// Free space sits in the top byte
					if (bus_ack) begin
						fifo_space <= bus_read_data[31:24];
						bus_read <= 1'b0;
						state <= drum_pkg::space_check;
					end
				end
				drum_pkg::space_check: begin
					if (fifo_space > `FIFO_MIN_SPACE && sample_ready) begin
						bus_addr <= `AUDIO_LEFT_ADDR;
						bus_write_data <= sample_word;
						bus_write <= 1'b1;
						state <= drum_pkg::left_wait;
					end else begin
						state <= drum_pkg::fifo_req;
					end
				end
				drum_pkg::left_wait: begin
					if (bus_ack) begin
						bus_write <= 1'b0;
						state <= drum_pkg::right_req;
					end
				end
				drum_pkg::right_req: begin
					// Same data word as the left channel
					bus_addr <= `AUDIO_RIGHT_ADDR;
					bus_write <= 1'b1;
					state <= drum_pkg::right_wait;
				end
				drum_pkg::right_wait: begin
					// Pair done, let the grid take its next step
					if (bus_ack) begin
						bus_write <= 1'b0;
						step_go <= 1'b1;
						state <= drum_pkg::fifo_req;
					end
				end
				default: begin
					state <= drum_pkg::fifo_req;
				end
			endcase
		end
	end

endmodule

/* drum_cfg.svh */
`ifndef DRUM_CFG_SVH
`define DRUM_CFG_SVH

////////////////////////////////////////
// Grid size
////////////////////////////////////////
`define DRUM_COLS 8
`define DRUM_ROWS 16

// Node heights are signed 1.17 fixed point
`define NODE_W 18

// Pyramid step of 2^-8
`define INIT_STEP 512
// Base tension 0.25 and ceiling 0.49
`define RHO_BASE 32768
`define RHO_MAX 64225

////////////////////////////////////////
// Audio core registers
////////////////////////////////////////
`define AUDIO_FIFO_ADDR 32'h0000_3044
`define AUDIO_LEFT_ADDR 32'h0000_3048
`define AUDIO_RIGHT_ADDR 32'h0000_304C

// Write only when more words than this are free
`define FIFO_MIN_SPACE 8'd2
// Node height to 32-bit audio sample
`define SAMPLE_SHIFT 14

`endif

/* drum_column.sv */
`timescale 1ns/1ps
`include "drum_cfg.svh"

module drum_column #(
	parameter drum_pkg::col_idx_t col_index = '0
) (
	input logic CLOCK_50,
	input logic reset,
	input drum_pkg::node_t tension,
	input drum_pkg::node_t init_step,
	input drum_pkg::node_t left_height,
	input drum_pkg::node_t right_height,
	input logic step_go,
	output drum_pkg::node_t row_height,
	output drum_pkg::row_addr_t row_index,
	output logic step_done
);

	localparam int LAST_ROW = `DRUM_ROWS - 1;
	localparam int RISE_ROWS = (`DRUM_ROWS - 1) / 2;
	localparam int PEAK_ROW = `DRUM_ROWS / 2 - 1;
	localparam drum_pkg::col_idx_t LAST_COL = drum_pkg::col_idx_t'(`DRUM_COLS - 1);

	drum_pkg::column_state_t state;
	drum_pkg::row_addr_t row_idx;
	drum_pkg::row_addr_t load_idx;
	drum_pkg::node_t load_height;
	drum_pkg::node_t center_reg;
	drum_pkg::node_t down_reg;
	drum_pkg::node_t curr_q;
	drum_pkg::node_t prev_q;
	drum_pkg::node_t curr_d;
	drum_pkg::node_t prev_d;
	drum_pkg::node_t up_nb;
	drum_pkg::node_t left_nb;
	drum_pkg::node_t right_nb;
	drum_pkg::node_t next_height;
	drum_pkg::row_addr_t curr_rd;
	drum_pkg::row_addr_t prev_rd;
	drum_pkg::row_addr_t wr_addr;
	logic ram_we;

	////////////////////////////////////////
	// Row memories
	////////////////////////////////////////

	// Up neighbor is read two rows ahead, prev one row ahead
	always_comb begin
		curr_rd = '0;
		prev_rd = '0;
		if (state == drum_pkg::col_prime) begin
			curr_rd = drum_pkg::row_addr_t'(1);
		end else if (state == drum_pkg::col_sweep) begin
			curr_rd = row_idx + drum_pkg::row_addr_t'(2);
			prev_rd = row_idx + drum_pkg::row_addr_t'(1);
		end
	end

	assign ram_we = (state == drum_pkg::col_load) || (state == drum_pkg::col_sweep);
	assign wr_addr = (state == drum_pkg::col_load) ? load_idx : row_idx;
	// Pyramid goes into both, so the drum starts at rest
	assign curr_d = (state == drum_pkg::col_load) ? load_height : next_height;
	assign prev_d = (state == drum_pkg::col_load) ? load_height : center_reg;

	row_ram curr_ram (
		.CLOCK_50(CLOCK_50),
		.we(ram_we),
		.write_addr(wr_addr),
		.read_addr(curr_rd),
		.d(curr_d),
		.q(curr_q)
	);

	row_ram prev_ram (
		.CLOCK_50(CLOCK_50),
		.we(ram_we),
		.write_addr(wr_addr),
		.read_addr(prev_rd),
		.d(prev_d),
		.q(prev_q)
	);

	////////////////////////////////////////
	// Node update
	////////////////////////////////////////

	// Nothing beyond the top row or the outer columns
	assign up_nb = (row_idx == LAST_ROW) ? '0 : curr_q;
	assign left_nb = (col_index == '0) ? '0 : left_height;
	assign right_nb = (col_index == LAST_COL) ? '0 : right_height;

	node_update u_update (
		.tension(tension),
		.center(center_reg),
		.prev(prev_q),
		.left(left_nb),
		.right(right_nb),
		.up(up_nb),
		.down(down_reg),
		.next_height(next_height)
	);

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			state <= drum_pkg::col_clear;
			row_idx <= '0;
			load_idx <= '0;
		end else begin
			case (state)
				drum_pkg::col_clear: begin
					row_idx <= '0;
					load_idx <= '0;
					load_height <= init_step;
					center_reg <= '0;
					down_reg <= '0;
					state <= drum_pkg::col_load;
				end
				drum_pkg::col_load: begin
					// Ramp up to the middle row, flat at the peak, then back down
					if (load_idx < RISE_ROWS) begin
						load_height <= load_height + init_step;
					end else if (load_idx != PEAK_ROW) begin
						load_height <= load_height - init_step;
					end
					load_idx <= load_idx + drum_pkg::row_addr_t'(1);
					if (load_idx == LAST_ROW) begin
						state <= drum_pkg::col_prime;
					end
				end
				drum_pkg::col_prime: begin
					// Row 0 was read in the cycle before
					center_reg <= curr_q;
					down_reg <= '0;
					row_idx <= '0;
					state <= drum_pkg::col_sweep;
				end
				drum_pkg::col_sweep: begin
					if (row_idx == LAST_ROW) begin
						state <= drum_pkg::col_hold;
					end else begin
						down_reg <= center_reg;
						center_reg <= curr_q;
						row_idx <= row_idx + drum_pkg::row_addr_t'(1);
					end
				end
				drum_pkg::col_hold: begin
					if (step_go) begin
						state <= drum_pkg::col_prime;
					end
				end
				default: begin
					state <= drum_pkg::col_clear;
				end
			endcase
		end
	end

	assign row_height = center_reg;
	assign row_index = row_idx;
	assign step_done = (state == drum_pkg::col_hold);

endmodule

/* drum_grid.sv */
`timescale 1ns/1ps
`include "drum_cfg.svh"

module drum_grid (
	input logic CLOCK_50,
	input logic reset,
	input logic step_go,
	output drum_pkg::node_t sample,
	output logic sample_ready
);

	localparam int CENTER_COL = `DRUM_COLS / 2;
	localparam int CENTER_ROW = `DRUM_ROWS / 2;
	localparam int LAST_ROW = `DRUM_ROWS - 1;

	drum_pkg::node_t heights [`DRUM_COLS];
	drum_pkg::node_t left_in [`DRUM_COLS];
	drum_pkg::node_t right_in [`DRUM_COLS];
	drum_pkg::row_addr_t row_at [`DRUM_COLS];
	logic [`DRUM_COLS-1:0] done;
	drum_pkg::node_t sample_scaled;
	drum_pkg::node_t rho_sum;
	drum_pkg::node_t tension;
	drum_pkg::node_t center_capture;

	////////////////////////////////////////
	// Amplitude dependent tension
	////////////////////////////////////////
	assign sample_scaled = sample >>> 4;
	assign rho_sum = drum_pkg::node_t'(`RHO_BASE) + drum_pkg::fix_mul(sample_scaled, sample_scaled);
	assign tension = (rho_sum > drum_pkg::node_t'(`RHO_MAX)) ?
		drum_pkg::node_t'(`RHO_MAX) : rho_sum;

	for (genvar c = 0; c < `DRUM_COLS; c++) begin : gen_col
		// Pyramid slope grows toward the middle columns
		localparam int EDGE_DIST = (c < `DRUM_COLS - 1 - c) ? c : `DRUM_COLS - 1 - c;

		if (c == 0) begin : gen_left_edge
			assign left_in[c] = '0;
		end else begin : gen_left
			assign left_in[c] = heights[c-1];
		end

		if (c == `DRUM_COLS - 1) begin : gen_right_edge
			assign right_in[c] = '0;
		end else begin : gen_right
			assign right_in[c] = heights[c+1];
		end

		drum_column #(
			.col_index(drum_pkg::col_idx_t'(c))
		) u_column (
			.CLOCK_50(CLOCK_50),
			.reset(reset),
			.tension(tension),
			.init_step(drum_pkg::node_t'((EDGE_DIST + 1) * `INIT_STEP)),
			.left_height(left_in[c]),
			.right_height(right_in[c]),
			.step_go(step_go),
			.row_height(heights[c]),
			.row_index(row_at[c]),
			.step_done(done[c])
		);
	end

	assign sample_ready = &done;

	// Columns run in lockstep, so column 0 gives the row for all of them
	// Center node captured as the sweep reaches it, before its update
	// Moved to sample on the last row so tension stays fixed for the whole sweep
	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			center_capture <= '0;
			sample <= '0;
		end else begin
			if (row_at[0] == CENTER_ROW) begin
				center_capture <= heights[CENTER_COL];
			end
			if (row_at[0] == LAST_ROW) begin
				sample <= center_capture;
			end
		end
	end

endmodule

/* drum_pkg.sv */
`include "drum_cfg.svh"

package drum_pkg;

	typedef logic signed [`NODE_W-1:0] node_t;
	typedef logic [$clog2(`DRUM_ROWS)-1:0] row_addr_t;
	typedef logic [$clog2(`DRUM_COLS)-1:0] col_idx_t;

	typedef enum logic [2:0] {
		col_clear,
		col_load,
		col_prime,
		col_sweep,
		col_hold
	} column_state_t;

	typedef enum logic [2:0] {
		fifo_req,
		fifo_wait,
		space_check,
		left_wait,
		right_req,
		right_wait
	} audio_state_t;

	// 1.17 times 1.17, keeps the sign and the upper fraction bits
	function automatic node_t fix_mul(input node_t a, input node_t b);
		logic signed [2*`NODE_W-1:0] full;
		full = a * b;
		return {full[2*`NODE_W-1], full[2*`NODE_W-3:`NODE_W-1]};
	endfunction

endpackage

/* drum_tb.sv */
`timescale 1ns/1ps
`include "drum_cfg.svh"

module drum_tb;

	localparam int RESET_CYCLES = 10;
	localparam int PAIRS = 40;
	localparam int RESTART_PAIR = 20;
	localparam int CENTER_COL = `DRUM_COLS / 2;
	localparam int CENTER_ROW = `DRUM_ROWS / 2;
	localparam int LOAD_CYCLES = RESET_CYCLES + `DRUM_ROWS + 2;
	localparam int CYCLE_LIMIT = 2 * (PAIRS * (`DRUM_ROWS + 2 + 40) + 2 * LOAD_CYCLES);
	localparam int NEXT_READ = 0;
	localparam int NEXT_ANY = 1;
	localparam int NEXT_RIGHT = 2;

	logic CLOCK_50;
	logic reset;
	logic bus_ack;
	logic [31:0] bus_read_data;
	logic [31:0] bus_addr;
	logic [3:0] bus_byte_enable;
	logic bus_read;
	logic bus_write;
	logic [31:0] bus_write_data;
	logic [7:0] fifo_space;

	integer seed;
	int errors;
	int cycles;
	int release_cycle;
	int pairs_done;
	int run_pair;
	int next_kind;
	int delay;
	bit ack_high;
	bit pending;
	bit first_request;
	bit restarted;
	bit timed_out;
	bit req_is_write;
	logic [31:0] req_addr;
	logic [31:0] left_data;
	logic [7:0] space_byte;

	// Reference drum state
	longint cur_grid [`DRUM_COLS][`DRUM_ROWS];
	longint prev_grid [`DRUM_COLS][`DRUM_ROWS];
	longint nxt_grid [`DRUM_COLS][`DRUM_ROWS];
	longint model_sample;

	tb_clock clock_gen (
		.CLOCK_50(CLOCK_50)
	);

	drum_top drum_top_inst (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.bus_ack(bus_ack),
		.bus_read_data(bus_read_data),
		.bus_addr(bus_addr),
		.bus_byte_enable(bus_byte_enable),
		.bus_read(bus_read),
		.bus_write(bus_write),
		.bus_write_data(bus_write_data),
		.fifo_space(fifo_space)
	);

	task compare_values(input logic [31:0] expected, input logic [31:0] actual,
		input string what);
		if (expected !== actual) begin
			errors++;
			$display("Fail at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
		end
	endtask

	////////////////////////////////////////
	// Fixed point reference arithmetic
	////////////////////////////////////////

	// Keep the low node bits as a signed height
	function automatic longint wrap_node(input longint v);
		logic signed [`NODE_W-1:0] t;
		t = v[`NODE_W-1:0];
		return t;
	endfunction

	// 1.17 product, sign bit above bits 33 to 17
	function automatic longint fixed_product(input longint a, input longint b);
		longint p;
		longint frac;
		p = a * b;
		frac = (p >>> (`NODE_W - 1)) & ((64'sd1 <<< (`NODE_W - 1)) - 1);
		if (p < 0) begin
			frac = frac - (64'sd1 <<< (`NODE_W - 1));
		end
		return frac;
	endfunction

	function automatic longint next_node(input longint t, input longint c, input longint p,
		input longint l, input longint r, input longint u, input longint d);
		longint lap;
		longint wave;
		lap = wrap_node(l + r + u + d - 4 * c);
		wave = wrap_node(fixed_product(lap, t) + 2 * c - p + (p >>> 10));
		return wrap_node(wave - (wave >>> 9));
	endfunction

	function automatic longint tension_of(input longint s);
		longint scaled;
		longint rho;
		scaled = s >>> 4;
		rho = wrap_node(`RHO_BASE + fixed_product(scaled, scaled));
		if (rho > `RHO_MAX) begin
			rho = `RHO_MAX;
		end
		return rho;
	endfunction

	function automatic logic [31:0] audio_word(input longint s);
		longint shifted;
		shifted = s <<< `SAMPLE_SHIFT;
		return shifted[31:0];
	endfunction

	// One time step; the sample is the center height as the step begins
	task model_step;
		int c;
		int r;
		longint capture;
		longint rho;
		longint l;
		longint rt;
		longint u;
		longint d;
		capture = cur_grid[CENTER_COL][CENTER_ROW];
		rho = tension_of(model_sample);
		for (c = 0; c < `DRUM_COLS; c++) begin
			for (r = 0; r < `DRUM_ROWS; r++) begin
				l = (c == 0) ? 0 : cur_grid[c-1][r];
				rt = (c == `DRUM_COLS - 1) ? 0 : cur_grid[c+1][r];
				d = (r == 0) ? 0 : cur_grid[c][r-1];
				u = (r == `DRUM_ROWS - 1) ? 0 : cur_grid[c][r+1];
				nxt_grid[c][r] = next_node(rho, cur_grid[c][r], prev_grid[c][r], l, rt, u, d);
			end
		end
		prev_grid = cur_grid;
		cur_grid = nxt_grid;
		model_sample = capture;
	endtask

	// Pyramid at rest, then the first step the grid runs by itself
	task model_reset;
		int c;
		int r;
		int col_f;
		int row_f;
		for (c = 0; c < `DRUM_COLS; c++) begin
			for (r = 0; r < `DRUM_ROWS; r++) begin
				col_f = ((c < `DRUM_COLS - 1 - c) ? c : `DRUM_COLS - 1 - c) + 1;
				row_f = (r + 1 < `DRUM_ROWS - r) ? r + 1 : `DRUM_ROWS - r;
				cur_grid[c][r] = col_f * row_f * `INIT_STEP;
				prev_grid[c][r] = cur_grid[c][r];
			end
		end
		model_sample = 0;
		model_step();
	endtask

	////////////////////////////////////////
	// Audio core side of the bus
	////////////////////////////////////////

	task apply_reset;
		int i;
		reset = 1'b1;
		bus_ack = 1'b0;
		bus_read_data = '0;
		ack_high = 1'b0;
		pending = 1'b0;
		for (i = 0; i < RESET_CYCLES; i++) begin
			@(negedge CLOCK_50);
			cycles++;
		end
		compare_values(0, bus_read, "bus_read in reset");
		compare_values(0, bus_write, "bus_write in reset");
		compare_values(0, drum_top_inst.step_go, "step_go in reset");
		compare_values(0, drum_top_inst.sample_ready, "sample_ready in reset");
		reset = 1'b0;
		release_cycle = cycles;
		first_request = 1'b1;
		next_kind = NEXT_READ;
		run_pair = 0;
		model_reset();
	endtask

	task start_request;
		int pick;
		pending = 1'b1;
		req_is_write = bus_write;
		req_addr = bus_addr;
		delay = {$random(seed)} % 6;
		compare_values(4'hF, bus_byte_enable, "byte enable");
		compare_values(1, bus_read ^ bus_write, "single request");
		if (first_request) begin
			first_request = 1'b0;
			compare_values(1, cycles - release_cycle, "cycles from reset to first read");
		end
		if (next_kind == NEXT_RIGHT) begin
			compare_values(1, bus_write, "right channel write");
			compare_values(`AUDIO_RIGHT_ADDR, bus_addr, "right channel address");
			compare_values(left_data, bus_write_data, "right data equals left data");
		end else if (next_kind == NEXT_ANY && bus_write) begin
			compare_values(`AUDIO_LEFT_ADDR, bus_addr, "left channel address");
			left_data = bus_write_data;
			compare_values(audio_word(model_sample), bus_write_data,
				$sformatf("sample of step %0d", run_pair + 1));
		end else begin
			compare_values(1, bus_read, "FIFO read expected");
			compare_values(`AUDIO_FIFO_ADDR, bus_addr, "FIFO address");
		end
		// Low space in about a third of the reads
		pick = {$random(seed)} % 3;
		if (pick == 0) begin
			space_byte = 8'({$random(seed)} % 3);
		end else begin
			space_byte = 8'(3 + {$random(seed)} % 253);
		end
	endtask

	task serve_cycle;
		@(negedge CLOCK_50);
		cycles++;
		if (ack_high) begin
			bus_ack = 1'b0;
			ack_high = 1'b0;
			compare_values(0, {bus_read, bus_write}, "request after acknowledge");
			if (!req_is_write) begin
				compare_values(space_byte, fifo_space, "fifo_space after read");
				next_kind = (space_byte > `FIFO_MIN_SPACE) ? NEXT_ANY : NEXT_READ;
			end else if (req_addr == `AUDIO_LEFT_ADDR) begin
				next_kind = NEXT_RIGHT;
			end else begin
				pairs_done++;
				run_pair++;
				next_kind = NEXT_READ;
				model_step();
			end
		end else if (bus_read || bus_write) begin
			if (!pending) begin
				start_request();
			end
			if (delay == 0) begin
				bus_ack = 1'b1;
				ack_high = 1'b1;
				pending = 1'b0;
				bus_read_data = {space_byte, 24'($random(seed))};
			end else begin
				delay--;
			end
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		seed = 18;
		errors = 0;
		cycles = 0;
		pairs_done = 0;
		restarted = 1'b0;
		timed_out = 1'b0;
		reset = 1'b1;
		bus_ack = 1'b0;
		bus_read_data = '0;
		apply_reset();
		while (pairs_done < PAIRS && !timed_out) begin
			serve_cycle();
			if (pairs_done == RESTART_PAIR && !restarted) begin
				restarted = 1'b1;
				apply_reset();
			end
			if (cycles >= CYCLE_LIMIT) begin
				timed_out = 1'b1;
			end
		end
		if (timed_out) begin
			$display("Timeout: the run reached %0d cycles with %0d of %0d write pairs done",
				cycles, pairs_done, PAIRS);
		end
		$display("Errors: %0d, write pairs: %0d", errors, pairs_done);
		if (errors == 0 && !timed_out) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* drum_top.sv */
`timescale 1ns/1ps
`include "drum_cfg.svh"

module drum_top (
	input logic CLOCK_50,
	input logic reset,
	input logic bus_ack,
	input logic [31:0] bus_read_data,
	output logic [31:0] bus_addr,
	output logic [3:0] bus_byte_enable,
	output logic bus_read,
	output logic bus_write,
	output logic [31:0] bus_write_data,
	output logic [7:0] fifo_space
);

	logic signed [`NODE_W-1:0] sample;
	logic sample_ready;
	logic step_go;

	// Wave simulation
	drum_grid u_grid (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.step_go(step_go),
		.sample(sample),
		.sample_ready(sample_ready)
	);

	// Audio core feeder
	audio_bus_master u_master (
		.CLOCK_50(CLOCK_50),
		.reset(reset),
		.sample(sample),
		.sample_ready(sample_ready),
		.bus_ack(bus_ack),
		.bus_read_data(bus_read_data),
		.bus_addr(bus_addr),
		.bus_byte_enable(bus_byte_enable),
		.bus_read(bus_read),
		.bus_write(bus_write),
		.bus_write_data(bus_write_data),
		.fifo_space(fifo_space),
		.step_go(step_go)
	);

endmodule

/* node_update.sv */
`timescale 1ns/1ps

module node_update (
	input drum_pkg::node_t tension,
	input drum_pkg::node_t center,
	input drum_pkg::node_t prev,
	input drum_pkg::node_t left,
	input drum_pkg::node_t right,
	input drum_pkg::node_t up,
	input drum_pkg::node_t down,
	output drum_pkg::node_t next_height
);

	drum_pkg::node_t lap_sum;
	drum_pkg::node_t lap_scaled;
	drum_pkg::node_t undamped;

	// Discrete Laplacian around the node
	assign lap_sum = left + right + up + down - (center <<< 2);
	assign lap_scaled = drum_pkg::fix_mul(lap_sum, tension);

	// Leapfrog step, with a small pull back toward the previous height
	assign undamped = lap_scaled + (center <<< 1) - prev + (prev >>> 10);

	// Damping
	assign next_height = undamped - (undamped >>> 9);

endmodule

/* row_ram.sv */
`timescale 1ns/1ps
`include "drum_cfg.svh"

module row_ram (
	input logic CLOCK_50,
	input logic we,
	input drum_pkg::row_addr_t write_addr,
	input drum_pkg::row_addr_t read_addr,
	input drum_pkg::node_t d,
	output drum_pkg::node_t q
);

	drum_pkg::node_t mem [`DRUM_ROWS];

	// Registered read, old data on a same-address write
	always_ff @(posedge CLOCK_50) begin
		if (we) begin
			mem[write_addr] <= d;
		end
		q <= mem[read_addr];
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the drum testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module drum_tb -f verilog.f -o drum_sim \
	&& ./obj_dir/drum_sim > "$LOG" 2>&1 \
	|| { echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"

grep -q "Testbench failed" "$LOG" && exit 1 || exit 0

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic CLOCK_50
);

	// 4 ns period
	initial begin
		CLOCK_50 = 1'b0;
		forever begin
			#2 CLOCK_50 = ~CLOCK_50;
		end
	end

endmodule

/* verilog.f */
+incdir+.
drum_pkg.sv
row_ram.sv
node_update.sv
drum_column.sv
drum_grid.sv
audio_bus_master.sv
drum_top.sv
tb_clock.sv
drum_tb.sv
